//--- src/tcb_defines.svh
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

//////////////////////////////
// interconnect size
//////////////////////////////

// number of bus managers
`define TCB_IFN 3
// manager select width
`define TCB_IFL 2

//////////////////////////////
// bus widths
//////////////////////////////

// byte address
`define TCB_ADR 32
// data word
`define TCB_DAT 32
// byte lanes per word
`define TCB_BYT 4

// memory depth in words
`define TCB_MEM_WORDS 256
// response delay in cycles
`define TCB_DLY 1

`endif

//--- src/tcb_pkg.sv
`include "tcb_defines.svh"

package tcb_pkg;

    //////////////////////////////
    // request fields
    //////////////////////////////

    // byte address
    typedef logic [`TCB_ADR-1:0] tcb_adr_t;

    // byte enables, one per lane
    typedef logic [`TCB_BYT-1:0] tcb_byt_t;

    //////////////////////////////
    // data word
    //////////////////////////////

    // whole word or per-lane view
    // byte view is used for enable merging
    typedef union packed {
        logic [`TCB_DAT-1:0]      wrd;
        logic [`TCB_BYT-1:0][7:0] byt;
    } tcb_data_u;

endpackage: tcb_pkg

//--- src/tcb_arbiter.sv
`timescale 1ns/10ps
`include "tcb_defines.svh"

module tcb_arbiter (
    input  logic                man,
    input  logic                rst_n,
    // manager handshake
    input  logic                vld [`TCB_IFN-1:0],
    input  logic                lck [`TCB_IFN-1:0],
    // subordinate ready
    input  logic                rdy,
    // grant
    output logic [`TCB_IFL-1:0] sel,
    output logic                trn
);

    localparam int unsigned IFN = `TCB_IFN;
    localparam int unsigned IFL = `TCB_IFL;

    //////////////////////////////
    // state
    //////////////////////////////

    // last granted manager
    logic [IFL-1:0] lst;
    // lock hold on lst
    logic           hld;

    //////////////////////////////
    // selection
    //////////////////////////////

    always_comb begin
        int unsigned idx;
        logic        fnd;
        idx = 0;
        fnd = 1'b0;
        // idle default, keeps last grant
        sel = lst;
        if (hld && vld[lst]) begin
            // locked sequence keeps the bus
            sel = lst;
        end else begin
            // first valid after the last grant, wrapping around
            for (int unsigned i = 1; i <= IFN; i++) begin
                idx = (int'(lst) + i) % IFN;
                if (!fnd && vld[idx]) begin
                    sel = idx[IFL-1:0];
                    fnd = 1'b1;
                end
            end
        end
    end

    // transfer strobe, selected valid meets ready
    assign trn = vld[sel] & rdy;

    //////////////////////////////
    // pointer and lock
    //////////////////////////////

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            // start so that manager 0 wins first
            lst <= IFL'(IFN-1);
            hld <= 1'b0;
        end else if (trn) begin
            lst <= sel;
            hld <= lck[sel];
        end else if (hld && !vld[lst]) begin
            // locked manager went away
            hld <= 1'b0;
        end
    end

endmodule: tcb_arbiter

//--- src/tcb_multiplexer.sv
`timescale 1ns/10ps
`include "tcb_defines.svh"

module tcb_multiplexer #(
    parameter  int unsigned IFN = `TCB_IFN,
    localparam int unsigned IFL = $clog2(IFN)
)(
    input  logic                man,
    input  logic                rst_n,
    // arbiter control
    input  logic [IFL-1:0]      sel,
    input  logic                trn,
    // manager requests
    input  logic                req_vld [IFN-1:0],
    input  logic                req_wen [IFN-1:0],
    input  tcb_pkg::tcb_adr_t   req_adr [IFN-1:0],
    input  tcb_pkg::tcb_byt_t   req_byt [IFN-1:0],
    input  tcb_pkg::tcb_data_u  req_wdt [IFN-1:0],
    // manager ready and response
    output logic                req_rdy [IFN-1:0],
    output tcb_pkg::tcb_data_u  rsp_rdt [IFN-1:0],
    output logic                rsp_err [IFN-1:0],
    // subordinate request
    output logic                mem_vld,
    output logic                mem_wen,
    output tcb_pkg::tcb_adr_t   mem_adr,
    output tcb_pkg::tcb_byt_t   mem_byt,
    output tcb_pkg::tcb_data_u  mem_wdt,
    // subordinate ready and response
    input  logic                mem_rdy,
    input  tcb_pkg::tcb_data_u  mem_rdt,
    input  logic                mem_err
);

    //////////////////////////////
    // response routing
    //////////////////////////////

    // manager owning the next response
    logic [IFL-1:0] rsp_sel;
    // response due this cycle
    logic           rsp_act;

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            rsp_sel <= '0;
            rsp_act <= 1'b0;
        end else begin
            rsp_act <= trn;
            // route follows the issuing manager
            if (trn) begin
                rsp_sel <= sel;
            end
        end
    end

    //////////////////////////////
    // request path
    //////////////////////////////

    assign mem_vld = req_vld[sel];
    assign mem_wen = req_wen[sel];
    assign mem_adr = req_adr[sel];
    assign mem_byt = req_byt[sel];
    assign mem_wdt = req_wdt[sel];

    //////////////////////////////
    // per manager outputs
    //////////////////////////////

    for (genvar i = 0; i < IFN; i++) begin: gen_man
        // ready only to the selected valid manager
        assign req_rdy[i] = (sel == i[IFL-1:0]) && req_vld[i] && mem_rdy;
        // others see zero data and no error
        assign rsp_rdt[i] = (rsp_act && rsp_sel == i[IFL-1:0]) ? mem_rdt : '0;
        assign rsp_err[i] = rsp_act && (rsp_sel == i[IFL-1:0]) && mem_err;
    end: gen_man

endmodule: tcb_multiplexer

//--- src/tcb_memory.sv
`timescale 1ns/10ps
`include "tcb_defines.svh"

module tcb_memory (
    input  logic                man,
    input  logic                rst_n,
    // request
    input  logic                mem_vld,
    input  logic                mem_wen,
    input  tcb_pkg::tcb_adr_t   mem_adr,
    input  tcb_pkg::tcb_byt_t   mem_byt,
    input  tcb_pkg::tcb_data_u  mem_wdt,
    // ready and response
    output logic                mem_rdy,
    output tcb_pkg::tcb_data_u  mem_rdt,
    output logic                mem_err
);

    localparam int unsigned BYL = $clog2(`TCB_BYT);
    localparam int unsigned MAW = $clog2(`TCB_MEM_WORDS);

    //////////////////////////////
    // storage and decode
    //////////////////////////////

    tcb_pkg::tcb_data_u mem [0:`TCB_MEM_WORDS-1];

    logic           trn;
    // word index and range check
    logic [MAW-1:0] idx;
    logic           rng;

    assign trn = mem_vld & mem_rdy;
    assign idx = mem_adr[BYL +: MAW];
    // word address at or past the end is an error
    assign rng = (mem_adr >> BYL) < `TCB_MEM_WORDS;

    //////////////////////////////
    // write-back stage
    //////////////////////////////

    // write-back pending, blocks one cycle
    logic               wbk;
    logic               wbk_rng;
    // captured write request
    logic [MAW-1:0]     wbk_idx;
    tcb_pkg::tcb_byt_t  wbk_byt;
    tcb_pkg::tcb_data_u wbk_wdt;
    // merged word
    tcb_pkg::tcb_data_u mrg;

    assign mem_rdy = ~wbk;

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            wbk     <= 1'b0;
            wbk_rng <= 1'b0;
        end else begin
            wbk     <= trn & mem_wen;
            wbk_rng <= rng;
        end
    end

    always_ff @(posedge man) begin
        if (trn && mem_wen) begin
            wbk_idx <= idx;
            wbk_byt <= mem_byt;
            wbk_wdt <= mem_wdt;
        end
    end

    // enabled lanes replace stored bytes
    always_comb begin
        mrg = mem[wbk_idx];
        for (int unsigned b = 0; b < `TCB_BYT; b++) begin
            if (wbk_byt[b]) begin
                mrg.byt[b] = wbk_wdt.byt[b];
            end
        end
    end

    // out of range writes leave memory alone
    always_ff @(posedge man) begin
        if (wbk && wbk_rng) begin
            mem[wbk_idx] <= mrg;
        end
    end

    //////////////////////////////
    // response
    //////////////////////////////

    // read data only in the response cycle
    always_ff @(posedge man) begin
        if (trn && !mem_wen && rng) begin
            mem_rdt <= mem[idx];
        end else begin
            mem_rdt <= '0;
        end
    end

    always_ff @(posedge man or negedge rst_n) begin
        if (!rst_n) begin
            mem_err <= 1'b0;
        end else begin
            mem_err <= trn & ~rng;
        end
    end

endmodule: tcb_memory

//--- src/tcb_interconnect.sv
`timescale 1ns/10ps
`include "tcb_defines.svh"

module tcb_interconnect (
    input  logic                man,
    input  logic                rst_n,
    // manager requests
    input  logic                req_vld [`TCB_IFN-1:0],
    input  logic                req_lck [`TCB_IFN-1:0],
    input  logic                req_wen [`TCB_IFN-1:0],
    input  tcb_pkg::tcb_adr_t   req_adr [`TCB_IFN-1:0],
    input  tcb_pkg::tcb_byt_t   req_byt [`TCB_IFN-1:0],
    input  tcb_pkg::tcb_data_u  req_wdt [`TCB_IFN-1:0],
    // manager ready and response
    output logic                req_rdy [`TCB_IFN-1:0],
    output tcb_pkg::tcb_data_u  rsp_rdt [`TCB_IFN-1:0],
    output logic                rsp_err [`TCB_IFN-1:0]
);

    //////////////////////////////
    // internal wiring
    //////////////////////////////

    // grant
    logic [`TCB_IFL-1:0] sel;
    logic                trn;

    // memory side
    logic                mem_vld;
    logic                mem_wen;
    tcb_pkg::tcb_adr_t   mem_adr;
    tcb_pkg::tcb_byt_t   mem_byt;
    tcb_pkg::tcb_data_u  mem_wdt;
    logic                mem_rdy;
    tcb_pkg::tcb_data_u  mem_rdt;
    logic                mem_err;

    //////////////////////////////
    // instances
    //////////////////////////////

    tcb_arbiter u_tcb_arbiter (
        .man   (man),
        .rst_n (rst_n),
        .vld   (req_vld),
        .lck   (req_lck),
        .rdy   (mem_rdy),
        .sel   (sel),
        .trn   (trn)
    );

    tcb_multiplexer #(.IFN(`TCB_IFN)) u_tcb_multiplexer (
        .man     (man),
        .rst_n   (rst_n),
        .sel     (sel),
        .trn     (trn),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_byt (req_byt),
        .req_wdt (req_wdt),
        .req_rdy (req_rdy),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_byt (mem_byt),
        .mem_wdt (mem_wdt),
        .mem_rdy (mem_rdy),
        .mem_rdt (mem_rdt),
        .mem_err (mem_err)
    );

    tcb_memory u_tcb_memory (
        .man     (man),
        .rst_n   (rst_n),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_byt (mem_byt),
        .mem_wdt (mem_wdt),
        .mem_rdy (mem_rdy),
        .mem_rdt (mem_rdt),
        .mem_err (mem_err)
    );

endmodule: tcb_interconnect

//--- sim/tcb_tb_assertions.sv
`timescale 1ns/10ps
`include "tcb_defines.svh"

module tcb_tb_assertions (
    input logic                man,
    input logic                rst_n,
    // manager side
    input logic                req_vld [`TCB_IFN-1:0],
    input logic                req_lck [`TCB_IFN-1:0],
    input logic                req_wen [`TCB_IFN-1:0],
    input tcb_pkg::tcb_adr_t   req_adr [`TCB_IFN-1:0],
    input tcb_pkg::tcb_byt_t   req_byt [`TCB_IFN-1:0],
    input tcb_pkg::tcb_data_u  req_wdt [`TCB_IFN-1:0],
    input logic                req_rdy [`TCB_IFN-1:0],
    // memory side
    input logic                mem_vld,
    input logic                mem_wen,
    input logic                mem_rdy
);

    // failed assertion count, read by the testbench
    int unsigned fire_cnt = 0;

    // ready bits as one vector
    logic [`TCB_IFN-1:0] rdy_vec;

    //////////////////////////////
    // per manager
    //////////////////////////////

    for (genvar i = 0; i < `TCB_IFN; i++) begin: gen_man
        assign rdy_vec[i] = req_rdy[i];

        // stalled request held as is
        a_hold: assert property (@(posedge man) disable iff (!rst_n)
            req_vld[i] && !req_rdy[i] |=> req_vld[i] && $stable(req_lck[i])
                && $stable(req_wen[i]) && $stable(req_adr[i])
                && $stable(req_byt[i]) && $stable(req_wdt[i]))
        else begin
            $error("manager %0d changed its request while stalled", i);
            fire_cnt++;
        end
    end: gen_man

    //////////////////////////////
    // shared bus
    //////////////////////////////

    a_one_rdy: assert property (@(posedge man) disable iff (!rst_n) $onehot0(rdy_vec))
    else begin
        $error("more than one manager sees ready");
        fire_cnt++;
    end

    // write-back cycle blocks the memory
    a_wbk: assert property (@(posedge man) disable iff (!rst_n)
        mem_vld && mem_rdy && mem_wen |=> !mem_rdy)
    else begin
        $error("memory ready right after a write transfer");
        fire_cnt++;
    end

endmodule: tcb_tb_assertions

//--- sim/tcb_tb.sv
`timescale 1ns/10ps
`include "tcb_defines.svh"

module tcb_tb;

    localparam int unsigned IFN    = `TCB_IFN;
    localparam int unsigned IFL    = `TCB_IFL;
    localparam int unsigned BYL    = $clog2(`TCB_BYT);
    localparam int unsigned WORDS  = `TCB_MEM_WORDS;
    localparam int unsigned PERIOD = 100;
    // transfers per test
    localparam int unsigned N_SINGLE = 2 * IFN;
    localparam int unsigned N_FILL   = WORDS;
    localparam int unsigned N_MERGE  = 8;
    localparam int unsigned N_RR     = 6 * IFN;
    localparam int unsigned N_LOCK   = 8;
    localparam int unsigned N_RANGE  = 5;
    localparam int unsigned N_RAND   = 200;
    localparam int unsigned N_ALL    = N_SINGLE + N_FILL + N_MERGE + N_RR + N_LOCK + N_RANGE
                                     + N_RAND;
    // eight cycles per transfer, plus reset
    localparam int unsigned WDOG_CYCLES = 16 + 8 * N_ALL;

    // one queued manager request
    typedef struct packed {
        logic               lck;
        logic               wen;
        tcb_pkg::tcb_adr_t  adr;
        tcb_pkg::tcb_byt_t  byt;
        tcb_pkg::tcb_data_u wdt;
    } req_t;

    //////////////////////////////
    // DUT and bind
    //////////////////////////////

    logic               man;
    logic               rst_n;
    logic               req_vld [`TCB_IFN-1:0];
    logic               req_lck [`TCB_IFN-1:0];
    logic               req_wen [`TCB_IFN-1:0];
    tcb_pkg::tcb_adr_t  req_adr [`TCB_IFN-1:0];
    tcb_pkg::tcb_byt_t  req_byt [`TCB_IFN-1:0];
    tcb_pkg::tcb_data_u req_wdt [`TCB_IFN-1:0];
    logic               req_rdy [`TCB_IFN-1:0];
    tcb_pkg::tcb_data_u rsp_rdt [`TCB_IFN-1:0];
    logic               rsp_err [`TCB_IFN-1:0];

    tcb_interconnect u_tcb_interconnect (
        .man     (man),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req_lck (req_lck),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_byt (req_byt),
        .req_wdt (req_wdt),
        .req_rdy (req_rdy),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    bind tcb_interconnect tcb_tb_assertions u_tcb_tb_assertions (
        .man     (man),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req_lck (req_lck),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_byt (req_byt),
        .req_wdt (req_wdt),
        .req_rdy (req_rdy),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_rdy (mem_rdy)
    );

    initial begin
        man = 1'b0;
        forever #(PERIOD/2) man = ~man;
    end

    // hard stop if a handshake never completes
    initial begin
        #(WDOG_CYCLES * PERIOD);
        $display("timeout: tests did not finish within %0d clock cycles", WDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // reference model, checks
    //////////////////////////////

    tcb_pkg::tcb_data_u ref_mem [0:WORDS-1];
    req_t               req_q [IFN][$];
    // manager index of every transfer, in order
    logic [IFL-1:0]     grant_log [$];
    int unsigned        xfer_cnt;
    int unsigned        pass_cnt;
    int unsigned        fail_cnt;

    // byte address below the end of the memory
    function automatic logic in_range(input tcb_pkg::tcb_adr_t adr);
        return adr < WORDS * `TCB_BYT;
    endfunction

    // enabled lanes take the new bytes, others keep the old ones
    function automatic void model_write(input req_t r);
        tcb_pkg::tcb_data_u w;
        if (in_range(r.adr)) begin
            w = ref_mem[r.adr >> BYL];
            for (int b = 0; b < `TCB_BYT; b++) begin
                if (r.byt[b]) begin
                    w.byt[b] = r.wdt.byt[b];
                end
            end
            ref_mem[r.adr >> BYL] = w;
        end
    endfunction

    function automatic req_t make_req(input logic lck, input logic wen, input int unsigned word,
                                      input tcb_pkg::tcb_byt_t byt, input logic [31:0] dat);
        req_t r;
        r.lck     = lck;
        r.wen     = wen;
        r.adr     = word << BYL;
        r.byt     = byt;
        r.wdt.wrd = dat;
        return r;
    endfunction

    // fill word built from the full word index
    function automatic logic [31:0] fill_word(input int unsigned i);
        return {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h17, i[7:0]};
    endfunction

    task automatic check_data(input string name, input tcb_pkg::tcb_data_u exp,
                              input tcb_pkg::tcb_data_u act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s: expected %h, got %h", $time, name, exp.wrd, act.wrd);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s: expected %b, got %b", $time, name, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_rdy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s: expected %b, got %b", $time, name, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_grant(input string name, input logic [IFL-1:0] exp,
                               input logic [IFL-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %0t ns %s: expected %0d, got %0d", $time, name, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int unsigned base);
        $display("test %s finished, %0d failed checks", name, fail_cnt - base);
    endtask

    //////////////////////////////
    // manager driver
    //////////////////////////////

    task automatic drive_req(input int unsigned m, input req_t r);
        req_vld[m] <= 1'b1;
        req_lck[m] <= r.lck;
        req_wen[m] <= r.wen;
        req_adr[m] <= r.adr;
        req_byt[m] <= r.byt;
        req_wdt[m] <= r.wdt;
    endtask

    // runs the queue of manager m back to back, checks each response
    task automatic run_seq(input int unsigned m);
        req_t               cur;
        tcb_pkg::tcb_data_u exp_rdt;
        logic               exp_err;
        logic               rd;
        logic               pend;
        @(posedge man);
        cur = req_q[m].pop_front();
        drive_req(m, cur);
        pend = 1'b1;
        @(negedge man);
        while (pend) begin
            // stalled until ready reaches this manager
            while (req_rdy[m] !== 1'b1) @(negedge man);
            @(posedge man);
            // transfer edge, the model follows DUT order
            grant_log.push_back(IFL'(m));
            xfer_cnt++;
            rd      = !cur.wen;
            exp_err = !in_range(cur.adr);
            exp_rdt = '0;
            if (rd && !exp_err) begin
                exp_rdt = ref_mem[cur.adr >> BYL];
            end
            if (cur.wen) begin
                model_write(cur);
            end
            // next request goes out on the same edge
            if (req_q[m].size() > 0) begin
                cur = req_q[m].pop_front();
                drive_req(m, cur);
            end else begin
                req_vld[m] <= 1'b0;
                req_lck[m] <= 1'b0;
                pend = 1'b0;
            end
            // response cycle
            @(negedge man);
            check_err($sformatf("rsp_err[%0d]", m), exp_err, rsp_err[m]);
            if (rd) begin
                check_data($sformatf("rsp_rdt[%0d]", m), exp_rdt, rsp_rdt[m]);
            end
            // nothing leaks to the other managers
            for (int unsigned k = 0; k < IFN; k++) begin
                if (k != m) begin
                    check_data($sformatf("rsp_rdt[%0d]", k), '0, rsp_rdt[k]);
                    check_err($sformatf("rsp_err[%0d]", k), 1'b0, rsp_err[k]);
                end
            end
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_single();
        int unsigned base;
        base = fail_cnt;
        // idle bus after reset
        @(negedge man);
        for (int unsigned k = 0; k < IFN; k++) begin
            check_rdy($sformatf("req_rdy[%0d]", k), 1'b0, req_rdy[k]);
        end
        for (int unsigned m = 0; m < IFN; m++) begin
            req_q[m].push_back(make_req(1'b0, 1'b1, 4 + m, 4'hf, $urandom));
            req_q[m].push_back(make_req(1'b0, 1'b0, 4 + m, 4'hf, 0));
            run_seq(m);
        end
        finish_test("single", base);
    endtask

    task automatic test_fill();
        int unsigned base;
        base = fail_cnt;
        for (int unsigned i = 0; i < N_FILL; i++) begin
            req_q[0].push_back(make_req(1'b0, 1'b1, i, 4'hf, fill_word(i)));
        end
        run_seq(0);
        finish_test("fill", base);
    endtask

    task automatic test_merge();
        int unsigned       base;
        tcb_pkg::tcb_byt_t ena [4];
        base = fail_cnt;
        ena = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
        // partial write then read back, rotating managers
        for (int unsigned i = 0; i < N_MERGE / 2; i++) begin
            req_q[i % IFN].push_back(make_req(1'b0, 1'b1, 32, ena[i], $urandom));
            req_q[i % IFN].push_back(make_req(1'b0, 1'b0, 32, 4'hf, 0));
            run_seq(i % IFN);
        end
        finish_test("merge", base);
    endtask

    task automatic test_round_robin();
        int unsigned    base;
        int unsigned    g0;
        logic [IFL-1:0] exp;
        base = fail_cnt;
        g0   = grant_log.size();
        for (int unsigned m = 0; m < IFN; m++) begin
            for (int unsigned n = 0; n < N_RR / IFN; n++) begin
                req_q[m].push_back(make_req(1'b0, 1'($urandom), $urandom_range(16, 31),
                                            4'hf, $urandom));
            end
        end
        fork
            run_seq(0);
            run_seq(1);
            run_seq(2);
        join
        if (grant_log.size() - g0 != N_RR) begin
            $display("round robin saw %0d transfers instead of %0d", grant_log.size() - g0, N_RR);
            fail_cnt++;
        end
        // rotation starts after the last grant of the previous test
        for (int unsigned k = 0; k < N_RR && g0 + k < grant_log.size(); k++) begin
            exp = IFL'((grant_log[g0 - 1] + 1 + k) % IFN);
            check_grant("grant", exp, grant_log[g0 + k]);
        end
        finish_test("round_robin", base);
    endtask

    task automatic test_lock();
        int unsigned    base;
        int unsigned    g0;
        int unsigned    x0;
        logic [IFL-1:0] exp;
        base = fail_cnt;
        g0   = grant_log.size();
        x0   = xfer_cnt;
        // manager 1 locks, last request drops the lock
        for (int unsigned n = 0; n < N_LOCK - 2; n++) begin
            req_q[1].push_back(make_req(n != N_LOCK - 3, n % 2 == 0, 40 + n, 4'hf, $urandom));
        end
        req_q[0].push_back(make_req(1'b0, 1'b0, 40, 4'hf, 0));
        req_q[2].push_back(make_req(1'b0, 1'b0, 41, 4'hf, 0));
        fork
            run_seq(1);
            begin
                wait (xfer_cnt > x0);
                run_seq(0);
            end
            begin
                wait (xfer_cnt > x0);
                run_seq(2);
            end
        join
        if (grant_log.size() - g0 != N_LOCK) begin
            $display("lock test saw %0d transfers instead of %0d", grant_log.size() - g0, N_LOCK);
            fail_cnt++;
        end
        // holder keeps the bus, then rotation after it
        for (int unsigned k = 0; k < N_LOCK && g0 + k < grant_log.size(); k++) begin
            exp = (k < N_LOCK - 2) ? IFL'(1) : IFL'((1 + k - (N_LOCK - 3)) % IFN);
            check_grant("grant", exp, grant_log[g0 + k]);
        end
        finish_test("lock", base);
    endtask

    task automatic test_range();
        int unsigned base;
        req_t        r;
        base = fail_cnt;
        req_q[2].push_back(make_req(1'b0, 1'b1, WORDS, 4'hf, $urandom));
        run_seq(2);
        req_q[0].push_back(make_req(1'b0, 1'b0, WORDS, 4'hf, 0));
        run_seq(0);
        // aliased word stays as it was
        req_q[1].push_back(make_req(1'b0, 1'b0, 0, 4'hf, 0));
        run_seq(1);
        r     = make_req(1'b0, 1'b1, 0, 4'hf, $urandom);
        r.adr = 32'hffff_fff0;
        req_q[2].push_back(r);
        run_seq(2);
        req_q[0].push_back(make_req(1'b0, 1'b0, 252, 4'hf, 0));
        run_seq(0);
        finish_test("range", base);
    endtask

    task automatic test_random();
        int unsigned base;
        int unsigned m;
        base = fail_cnt;
        for (int unsigned i = 0; i < N_RAND; i++) begin
            m = $urandom_range(0, IFN - 1);
            req_q[m].push_back(make_req(1'b0, 1'($urandom), $urandom_range(0, WORDS - 1),
                                        4'($urandom), $urandom));
            run_seq(m);
        end
        finish_test("random", base);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'h39775d42));
        pass_cnt = 0;
        fail_cnt = 0;
        xfer_cnt = 0;
        rst_n    = 1'b0;
        for (int unsigned k = 0; k < IFN; k++) begin
            req_vld[k] = 1'b0;
            req_lck[k] = 1'b0;
            req_wen[k] = 1'b0;
            req_adr[k] = '0;
            req_byt[k] = '0;
            req_wdt[k] = '0;
        end
        repeat (16) @(posedge man);
        rst_n <= 1'b1;
        test_single();
        test_fill();
        test_merge();
        test_round_robin();
        test_lock();
        test_range();
        test_random();
        $display("checks passed %0d, checks failed %0d, assertion failures %0d",
                 pass_cnt, fail_cnt, u_tcb_interconnect.u_tcb_tb_assertions.fire_cnt);
        if (fail_cnt == 0 && u_tcb_interconnect.u_tcb_tb_assertions.fire_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule: tcb_tb

//--- flist.f
+incdir+src
src/tcb_pkg.sv
src/tcb_arbiter.sv
src/tcb_multiplexer.sv
src/tcb_memory.sv
src/tcb_interconnect.sv
sim/tcb_tb_assertions.sv
sim/tcb_tb.sv

//--- Makefile
# Verilator build and run of the interconnect testbench

VERILATOR ?= verilator
TOP       ?= tcb_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
